//--- patch_pkg.sv
package patch_pkg;

  // frame geometry of the feature map
  localparam int NUM_CH  = 4;
  localparam int FRAME_H = 7;
  localparam int FRAME_W = 7;

  // square patch taken at every window position
  localparam int PATCH_K = 3;

  // pixel width in bits
  localparam int PIX_W = 16;

  // legal window positions per channel
  localparam int WIN_ROWS = FRAME_H - PATCH_K + 1;
  localparam int WIN_COLS = FRAME_W - PATCH_K + 1;

  // one pixel sample
  typedef logic [PIX_W-1:0] pixel_t;

  // window position indices
  typedef logic [$clog2(NUM_CH)-1:0]   chan_t;
  typedef logic [$clog2(WIN_ROWS)-1:0] row_t;
  typedef logic [$clog2(WIN_COLS)-1:0] col_t;

  // scan controller states
  typedef enum logic {
    IDLE,
    SCAN
  } scan_state_t;

endpackage

//--- scan_pos_if.sv
interface scan_pos_if;

  // advance strobe from the controller
  logic step;

  // current window position
  patch_pkg::chan_t chan;
  patch_pkg::row_t  row;
  patch_pkg::col_t  col;

  // final window of the whole scan
  logic last;

  modport ctrl (
    output step,
    input  last
  );

  modport counter (
    input  step,
    output chan,
    output row,
    output col,
    output last
  );

  // extractor captures the window at the edge where step is high
  modport extractor (
    input step,
    input chan,
    input row,
    input col
  );

endinterface

//--- scan_ctrl.sv
module scan_ctrl (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  output logic       busy,
  scan_pos_if.ctrl   pos
);

  patch_pkg::scan_state_t state;
  patch_pkg::scan_state_t state_next;

  // next state
  always_comb begin
    state_next = state;
    case (state)
      patch_pkg::IDLE: begin
        // start only counts while idle
        if (start) begin
          state_next = patch_pkg::SCAN;
        end
      end
      patch_pkg::SCAN: begin
        // leave on the step that takes the final window
        if (pos.step && pos.last) begin
          state_next = patch_pkg::IDLE;
        end
      end
      default: begin
        state_next = patch_pkg::IDLE;
      end
    endcase
  end

  // state register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= patch_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // one step per cycle for the whole scan, no stalls
  assign pos.step = (state == patch_pkg::SCAN);

  assign busy = (state == patch_pkg::SCAN);

  // the counter must be back at the origin between scans
  property p_idle_not_last;
    @(posedge clk) disable iff (!rst_n)
      !busy |-> !pos.last;
  endproperty

  a_idle_not_last: assert property (p_idle_not_last)
    else $error("window counter not rewound while idle");

endmodule

//--- window_counter.sv
module window_counter (
  input  logic         clk,
  input  logic         rst_n,
  scan_pos_if.counter  pos
);

  patch_pkg::chan_t chan_q;
  patch_pkg::row_t  row_q;
  patch_pkg::col_t  col_q;

  logic col_last;
  logic row_last;
  logic chan_last;

  // end of each loop level, taken from the frame geometry
  assign col_last  = (col_q  == patch_pkg::col_t'(patch_pkg::WIN_COLS - 1));
  assign row_last  = (row_q  == patch_pkg::row_t'(patch_pkg::WIN_ROWS - 1));
  assign chan_last = (chan_q == patch_pkg::chan_t'(patch_pkg::NUM_CH - 1));

  // raster order: column fastest, then row, then channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chan_q <= '0;
      row_q  <= '0;
      col_q  <= '0;
    end else if (pos.step) begin
      if (col_last) begin
        col_q <= '0;
        if (row_last) begin
          row_q <= '0;
          // wraps to channel 0 after the final window
          if (chan_last) begin
            chan_q <= '0;
          end else begin
            chan_q <= chan_q + 1'b1;
          end
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  assign pos.chan = chan_q;
  assign pos.row  = row_q;
  assign pos.col  = col_q;
  assign pos.last = chan_last && row_last && col_last;

  // window must stay inside the frame
  property p_pos_in_range;
    @(posedge clk) disable iff (!rst_n)
      (row_q < patch_pkg::WIN_ROWS) && (col_q < patch_pkg::WIN_COLS);
  endproperty

  a_pos_in_range: assert property (p_pos_in_range)
    else $error("window position out of range");

endmodule

//--- patch_extractor.sv
module patch_extractor (
  input  logic                  clk,
  input  logic                  rst_n,
  input  patch_pkg::pixel_t     frame [patch_pkg::NUM_CH][patch_pkg::FRAME_H][patch_pkg::FRAME_W],
  scan_pos_if.extractor         pos,
  output patch_pkg::pixel_t     patch [patch_pkg::PATCH_K][patch_pkg::PATCH_K],
  output logic                  valid_patch
);

  // plane of the current channel
  patch_pkg::pixel_t plane  [patch_pkg::FRAME_H][patch_pkg::FRAME_W];

  // window at the current position
  patch_pkg::pixel_t window [patch_pkg::PATCH_K][patch_pkg::PATCH_K];

  // channel select first, then the 3x3 offsets inside the plane
  always_comb begin
    for (int r = 0; r < patch_pkg::FRAME_H; r++) begin
      for (int c = 0; c < patch_pkg::FRAME_W; c++) begin
        plane[r][c] = frame[pos.chan][r][c];
      end
    end
  end

  always_comb begin
    for (int r = 0; r < patch_pkg::PATCH_K; r++) begin
      for (int c = 0; c < patch_pkg::PATCH_K; c++) begin
        window[r][c] = plane[int'(pos.row) + r][int'(pos.col) + c];
      end
    end
  end

  // patch registers hold between scans
  always_ff @(posedge clk) begin
    if (pos.step) begin
      for (int r = 0; r < patch_pkg::PATCH_K; r++) begin
        for (int c = 0; c < patch_pkg::PATCH_K; c++) begin
          patch[r][c] <= window[r][c];
        end
      end
    end
  end

  // valid follows the step by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_patch <= 1'b0;
    end else begin
      valid_patch <= pos.step;
    end
  end

  // every burst of patches begins at channel 0, row 0, column 0
  property p_burst_from_origin;
    @(posedge clk) disable iff (!rst_n)
      $rose(valid_patch) |->
        $past((pos.chan == '0) && (pos.row == '0) && (pos.col == '0));
  endproperty

  a_burst_from_origin: assert property (p_burst_from_origin)
    else $error("first patch of a scan not taken at the origin");

endmodule

//--- patch_scanner.sv
module patch_scanner (
  input  logic               clk,
  input  logic               rst_n,

  // one-cycle start, sampled while idle
  input  logic               start,

  // held stable while busy
  input  patch_pkg::pixel_t  frame [patch_pkg::NUM_CH][patch_pkg::FRAME_H][patch_pkg::FRAME_W],

  output patch_pkg::pixel_t  patch [patch_pkg::PATCH_K][patch_pkg::PATCH_K],
  output logic               valid_patch,
  output logic               busy
);

  // position and step shared by the three blocks
  scan_pos_if pos ();

  // idle/scan sequencing
  scan_ctrl u_scan_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .pos   (pos.ctrl)
  );

  // raster walk over column, row and channel
  window_counter u_window_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos.counter)
  );

  // window select and output registers
  patch_extractor u_patch_extractor (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .pos         (pos.extractor),
    .patch       (patch),
    .valid_patch (valid_patch)
  );

endmodule

//--- patch_scanner_tb.sv
module patch_scanner_tb;

  localparam int CLK_PERIOD      = 8;
  localparam int K               = patch_pkg::PATCH_K;
  localparam int PW              = patch_pkg::PIX_W;
  localparam int NUM_PATCH       = patch_pkg::NUM_CH * patch_pkg::WIN_ROWS * patch_pkg::WIN_COLS;
  // tests 2, 3 and 4 run one scan each, test 5 runs five
  localparam int NUM_SCANS       = 8;
  localparam int WATCHDOG_CYCLES = NUM_SCANS * (NUM_PATCH + 20) + 50;

  typedef logic [K*K*PW-1:0] patch_bits_t;

  logic clk;
  logic rst_n;
  logic start;
  patch_pkg::pixel_t frame [patch_pkg::NUM_CH][patch_pkg::FRAME_H][patch_pkg::FRAME_W];
  patch_pkg::pixel_t patch [K][K];
  logic valid_patch;
  logic busy;

  // reference copy of the frame and the expected windows in raster order
  patch_pkg::pixel_t ref_frame [patch_pkg::NUM_CH][patch_pkg::FRAME_H][patch_pkg::FRAME_W];
  patch_bits_t exp_q [$];
  int          pos_q [$];

  integer seed;
  int error_cnt;
  int test_err_base;
  int pass_cnt;
  int fail_cnt;

  // monitor bookkeeping, cycle numbers counted at falling edges
  int   cyc;
  int   start_cyc;
  int   rise_cyc;
  int   valid_fall_cyc;
  int   busy_fall_cyc;
  int   run_len;
  int   patch_cnt;
  logic busy_prev;
  logic valid_prev;

  patch_scanner DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .frame       (frame),
    .patch       (patch),
    .valid_patch (valid_patch),
    .busy        (busy)
  );

  initial clk = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic log_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    error_cnt++;
  endtask

  task automatic finish_test(input string name);
    if (error_cnt == test_err_base) begin
      pass_cnt++;
      $display("Test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s: FAILED with %0d errors", name, error_cnt - test_err_base);
    end
    test_err_base = error_cnt;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      start = 1'b0;
    end
  endtask

  // new random frame, mirrored into the reference copy
  task automatic load_frame();
    logic [31:0] word;
    for (int ch = 0; ch < patch_pkg::NUM_CH; ch++) begin
      for (int r = 0; r < patch_pkg::FRAME_H; r++) begin
        for (int c = 0; c < patch_pkg::FRAME_W; c++) begin
          word = $random(seed);
          frame[ch][r][c]     = word[PW-1:0];
          ref_frame[ch][r][c] = word[PW-1:0];
        end
      end
    end
  endtask

  // walk channel, row, column and queue every 3x3 window
  task automatic build_model();
    patch_bits_t win;
    exp_q.delete();
    pos_q.delete();
    for (int ch = 0; ch < patch_pkg::NUM_CH; ch++) begin
      for (int r = 0; r < patch_pkg::WIN_ROWS; r++) begin
        for (int c = 0; c < patch_pkg::WIN_COLS; c++) begin
          for (int pr = 0; pr < K; pr++) begin
            for (int pc = 0; pc < K; pc++) begin
              win[(pr*K+pc)*PW +: PW] = ref_frame[ch][r+pr][c+pc];
            end
          end
          exp_q.push_back(win);
          pos_q.push_back(ch * 100 + r * 10 + c);
        end
      end
    end
  endtask

  // one scan, optionally with stray start pulses while busy
  task automatic run_scan(input bit extra_starts);
    int          cycles;
    bit          done;
    logic [31:0] word;
    @(posedge clk);
    #1;
    load_frame();
    build_model();
    patch_cnt = 0;
    start     = 1'b1;
    cycles    = 0;
    done      = 1'b0;
    while (!done && cycles < NUM_PATCH + 20) begin
      @(posedge clk);
      #1;
      cycles++;
      if (busy) begin
        word  = $random(seed);
        // at least one stray pulse lands in the middle of the scan
        start = extra_starts && (word[3:0] == 4'd0 || cycles == NUM_PATCH / 2);
      end else begin
        start = 1'b0;
        done  = 1'b1;
      end
    end
    assert (done) else log_error("scan did not finish, busy stayed high too long");
    // last patch is still on the outputs in this cycle
    @(negedge clk);
    #1;
    assert (patch_cnt == NUM_PATCH)
      else log_error($sformatf("got %0d patches, expected %0d", patch_cnt, NUM_PATCH));
    assert (exp_q.size() == 0)
      else log_error($sformatf("%0d model windows never delivered", exp_q.size()));
  endtask

  // checks every patch against the model and records the scan timing
  always @(negedge clk) begin
    patch_bits_t got;
    patch_bits_t want;
    int          where;
    if (rst_n) begin
      cyc = cyc + 1;
      if (start && !busy) begin
        start_cyc = cyc;
      end
      if (busy_prev && !busy) begin
        busy_fall_cyc = cyc;
      end
      if (valid_patch && !valid_prev) begin
        rise_cyc = cyc;
        run_len  = 0;
        assert (rise_cyc == start_cyc + 2)
          else log_error($sformatf("valid_patch rose in cycle %0d, expected %0d",
                                   rise_cyc, start_cyc + 2));
      end
      if (valid_patch) begin
        run_len++;
        patch_cnt++;
        for (int r = 0; r < K; r++) begin
          for (int c = 0; c < K; c++) begin
            got[(r*K+c)*PW +: PW] = patch[r][c];
          end
        end
        assert (exp_q.size() != 0)
          else log_error("a patch arrived with no window left in the model");
        if (exp_q.size() != 0) begin
          want  = exp_q.pop_front();
          where = pos_q.pop_front();
          assert (got == want)
            else log_error($sformatf("patch ch %0d row %0d col %0d expected %h got %h",
                                     where / 100, (where / 10) % 10, where % 10, want, got));
        end
      end
      if (!valid_patch && valid_prev) begin
        valid_fall_cyc = cyc;
        assert (valid_fall_cyc == busy_fall_cyc + 1)
          else log_error($sformatf("valid_patch fell in cycle %0d, busy fell in cycle %0d",
                                   valid_fall_cyc, busy_fall_cyc));
        assert (run_len == NUM_PATCH)
          else log_error($sformatf("valid_patch run of %0d cycles, expected %0d",
                                   run_len, NUM_PATCH));
      end
      busy_prev  = busy;
      valid_prev = valid_patch;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d clock cycles, the run did not complete",
             WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed           = 33197;
    error_cnt      = 0;
    test_err_base  = 0;
    pass_cnt       = 0;
    fail_cnt       = 0;
    cyc            = 0;
    start_cyc      = 0;
    rise_cyc       = 0;
    valid_fall_cyc = 0;
    busy_fall_cyc  = 0;
    run_len        = 0;
    patch_cnt      = 0;
    busy_prev      = 1'b0;
    valid_prev     = 1'b0;
    rst_n          = 1'b0;
    start          = 1'b0;
    for (int ch = 0; ch < patch_pkg::NUM_CH; ch++) begin
      for (int r = 0; r < patch_pkg::FRAME_H; r++) begin
        for (int c = 0; c < patch_pkg::FRAME_W; c++) begin
          frame[ch][r][c] = '0;
        end
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // outputs quiet until the first start
    repeat (10) begin
      @(posedge clk);
      #1;
      assert (!busy && !valid_patch) else log_error("busy or valid_patch high before any start");
    end
    finish_test("reset state");

    run_scan(1'b0);
    idle_cycles(3);
    finish_test("single scan");

    run_scan(1'b0);
    idle_cycles(3);
    assert (rise_cyc == start_cyc + 2)
      else log_error($sformatf("first patch in cycle %0d, start in cycle %0d",
                               rise_cyc, start_cyc));
    assert (valid_fall_cyc - rise_cyc == NUM_PATCH)
      else log_error($sformatf("valid_patch high for %0d cycles", valid_fall_cyc - rise_cyc));
    assert (valid_fall_cyc == busy_fall_cyc + 1)
      else log_error("valid_patch did not fall one cycle after busy");
    finish_test("contiguous timing");

    run_scan(1'b1);
    // stray starts must not launch a second scan
    repeat (10) begin
      @(posedge clk);
      #1;
      assert (!busy && !valid_patch) else log_error("a second scan followed an ignored start");
    end
    assert (patch_cnt == NUM_PATCH)
      else log_error($sformatf("patch count grew to %0d after the scan", patch_cnt));
    finish_test("start while busy");

    repeat (5) begin
      run_scan(1'b0);
    end
    idle_cycles(3);
    finish_test("repeated scans");

    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && error_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- patch_scanner.f
patch_pkg.sv
scan_pos_if.sv
scan_ctrl.sv
window_counter.sv
patch_extractor.sv
patch_scanner.sv
patch_scanner_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the patch scanner testbench with Verilator.
# Exits non-zero when the build fails, the simulator fails,
# or the log reports a failed regression.

TOP=patch_scanner_tb
FILELIST=patch_scanner.f
LOG=sim.log
FAIL_MSG="Regression failed"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" \
  -f "$FILELIST" \
  -o "V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Failure found in $LOG"
  exit 1
fi

echo "No failure found in $LOG"
exit 0
